/* hw/ohci_pkg.sv */
/*
  Shared types and constants of the OHCI list service.
  Descriptor addresses are 16-byte aligned and carry address bits [31:4] only.
  Frame timing is scaled down and does not model a real 1 ms frame.
*/

package ohci_pkg;

  // upper bit set for the nonperiodic lists
  typedef enum logic [1:0] {
    ISOCHRONOUS = 2'b00,
    INTERRUPT   = 2'b01,
    CONTROL     = 2'b10,
    BULK        = 2'b11
  } channel_e;

  // address bits [31:4] of an ED or TD
  localparam int ED_ADDR_W = 28;

  // frame cycle counter width
  localparam int FRAME_CNT_W = 8;

  // first count of the periodic zone
  localparam logic [FRAME_CNT_W-1:0] PERIODIC_START = 8'd24;

  // control/bulk service ratio input width
  localparam int CBSR_W = 2;

endpackage

/* hw/ohci_nextis_if.sv */
/*
  Next-descriptor handoff from the fetcher to the list service.
  valid is a one-cycle strobe and is only legal while ready is high.
*/

`timescale 1ns/1ns

interface ohci_nextis_if;

  logic                          valid;
  // 1 for an ED, 0 for a TD
  logic                          ed;
  ohci_pkg::channel_e            chan_type;
  logic [ohci_pkg::ED_ADDR_W-1:0] address;
  // registered level from the list service
  logic                          ready;

  modport source  (output valid, ed, chan_type, address, input ready);
  modport service (input valid, ed, chan_type, address, output ready);

endinterface

/* hw/ohci_edreg_if.sv */
/*
  Link between the list service and the ED pointer registers.
  One shared write data bus feeds all three current pointers.
  Clear pulses also copy the head into the matching current pointer.
*/

`timescale 1ns/1ns

interface ohci_edreg_if;

  // current pointer updates from the list service
  logic                          period_we;
  logic                          control_we;
  logic                          bulk_we;
  logic [ohci_pkg::ED_ADDR_W-1:0] cur_wdata;
  // end of a head access
  logic                          control_clr;
  logic                          bulk_clr;

  // stored values
  logic [ohci_pkg::ED_ADDR_W-1:0] period_q;
  logic [ohci_pkg::ED_ADDR_W-1:0] control_q;
  logic [ohci_pkg::ED_ADDR_W-1:0] bulk_q;
  logic [ohci_pkg::ED_ADDR_W-1:0] controlhead_q;
  logic [ohci_pkg::ED_ADDR_W-1:0] bulkhead_q;
  logic                          control_active;
  logic                          bulk_active;

  modport service (
    output period_we, control_we, bulk_we, cur_wdata, control_clr, bulk_clr,
    input  period_q, control_q, bulk_q, controlhead_q, bulkhead_q,
    input  control_active, bulk_active
  );

  modport regs (
    input  period_we, control_we, bulk_we, cur_wdata, control_clr, bulk_clr,
    output period_q, control_q, bulk_q, controlhead_q, bulkhead_q,
    output control_active, bulk_active
  );

endinterface

/* hw/ohci_ed_regs.sv */
/*
  ED pointer registers: period, control and bulk current plus two heads.
  A head write sets its active flag; a head rewrite in the clear cycle wins.
*/

`timescale 1ns/1ns

module ohci_ed_regs (
  input  logic                           clk_i,
  input  logic                           reset_i,
  input  logic                           controlhead_we_i,
  input  logic                           bulkhead_we_i,
  input  logic [ohci_pkg::ED_ADDR_W-1:0] head_addr_i,
  ohci_edreg_if.regs                     edreg
);

  logic [ohci_pkg::ED_ADDR_W-1:0] period_q;
  logic [ohci_pkg::ED_ADDR_W-1:0] control_q;
  logic [ohci_pkg::ED_ADDR_W-1:0] bulk_q;
  logic [ohci_pkg::ED_ADDR_W-1:0] controlhead_q;
  logic [ohci_pkg::ED_ADDR_W-1:0] bulkhead_q;
  logic                           control_active_q;
  logic                           bulk_active_q;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      period_q         <= '0;
      control_q        <= '0;
      bulk_q           <= '0;
      controlhead_q    <= '0;
      bulkhead_q       <= '0;
      control_active_q <= 1'b0;
      bulk_active_q    <= 1'b0;
    end else begin
      if (edreg.period_we) begin
        period_q <= edreg.cur_wdata;
      end
      // head copy at the end of a head access
      if (edreg.control_clr) begin
        control_q <= controlhead_q;
      end else if (edreg.control_we) begin
        control_q <= edreg.cur_wdata;
      end
      if (edreg.bulk_clr) begin
        bulk_q <= bulkhead_q;
      end else if (edreg.bulk_we) begin
        bulk_q <= edreg.cur_wdata;
      end
      // host writes to the head registers
      if (controlhead_we_i) begin
        controlhead_q <= head_addr_i;
      end
      if (bulkhead_we_i) begin
        bulkhead_q <= head_addr_i;
      end
      // a new write keeps the flag set
      if (controlhead_we_i) begin
        control_active_q <= 1'b1;
      end else if (edreg.control_clr) begin
        control_active_q <= 1'b0;
      end
      if (bulkhead_we_i) begin
        bulk_active_q <= 1'b1;
      end else if (edreg.bulk_clr) begin
        bulk_active_q <= 1'b0;
      end
    end
  end

  assign edreg.period_q       = period_q;
  assign edreg.control_q      = control_q;
  assign edreg.bulk_q         = bulk_q;
  assign edreg.controlhead_q  = controlhead_q;
  assign edreg.bulkhead_q     = bulkhead_q;
  assign edreg.control_active = control_active_q;
  assign edreg.bulk_active    = bulk_active_q;

endmodule

/* hw/ohci_frame_zone.sv */
/*
  Frame cycle counter; the frame starts nonperiodic and turns periodic.
  The count saturates, so a missing frame start leaves the frame periodic.
*/

`timescale 1ns/1ns

module ohci_frame_zone (
  input  logic clk_i,
  input  logic reset_i,
  input  logic frame_start_i,
  output logic periodic_o
);

  logic [ohci_pkg::FRAME_CNT_W-1:0] frame_cnt_q;
  logic                             frame_cnt_max;

  // all ones means saturated
  assign frame_cnt_max = &frame_cnt_q;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      frame_cnt_q <= '0;
    end else if (frame_start_i) begin
      // restart at every frame boundary
      frame_cnt_q <= '0;
    end else if (!frame_cnt_max) begin
      frame_cnt_q <= frame_cnt_q + 1'b1;
    end
  end

  // periodic zone from PERIODIC_START to the end of the frame
  assign periodic_o = (frame_cnt_q >= ohci_pkg::PERIODIC_START);

endmodule

/* hw/ohci_ratio_counter.sv */
/*
  Control/bulk service ratio counter.
  Counts control EDs since the last bulk ED or frame start.
  threshold_o stays high until a bulk ED is served or the frame restarts.
*/

`timescale 1ns/1ns

module ohci_ratio_counter (
  input  logic                        clk_i,
  input  logic                        reset_i,
  input  logic                        frame_start_i,
  input  logic [ohci_pkg::CBSR_W-1:0] cbsr_i,
  input  logic                        control_served_i,
  input  logic                        bulk_served_i,
  output logic                        threshold_o
);

  // one extra bit so the count can pass the largest ratio
  logic [ohci_pkg::CBSR_W:0] ratio_cnt_q;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      ratio_cnt_q <= '0;
    end else if (frame_start_i || bulk_served_i) begin
      // clear wins over a control pulse
      ratio_cnt_q <= '0;
    end else if (control_served_i && !(&ratio_cnt_q)) begin
      ratio_cnt_q <= ratio_cnt_q + 1'b1;
    end
  end

  // ratio used up, next nonperiodic ED goes to bulk
  assign threshold_o = (ratio_cnt_q > {1'b0, cbsr_i});

endmodule

/* hw/ohci_listservice.sv */
/*
  Chooses the next DMA read address and type with no register latency.
  Head accesses have priority and drop a nextis strobe in the same cycle.
  Every access is a read; there is no DMA back-pressure.
*/

`timescale 1ns/1ns

module ohci_listservice (
  input  logic                           clk_i,
  input  logic                           reset_i,
  input  logic                           periodic_i,
  input  logic                           threshold_i,
  ohci_nextis_if.service                 nextis,
  ohci_edreg_if.service                  edreg,
  output logic [ohci_pkg::ED_ADDR_W-1:0] dma_addr_o,
  output logic                           dma_valid_o,
  output ohci_pkg::channel_e             dma_type_o,
  output logic                           dma_is_ed_o
);

  logic any_active;
  logic bulk_head_acc;
  logic control_head_acc;
  logic nextis_accept;
  logic ed_accept;
  logic zone_mismatch;
  logic redirect;
  logic ready_q;

  // bulk head first, control head one cycle later
  assign any_active       = edreg.bulk_active || edreg.control_active;
  assign bulk_head_acc    = edreg.bulk_active;
  assign control_head_acc = edreg.control_active && !edreg.bulk_active;

  // strobe lost while a head is served
  assign nextis_accept = nextis.valid && !any_active;
  assign ed_accept     = nextis_accept && nextis.ed;

  // nonperiodic ED in the periodic zone or vice versa
  assign zone_mismatch = (nextis.chan_type[1] == periodic_i);
  assign redirect      = zone_mismatch || threshold_i;

  // remember the incoming ED in its own list
  assign edreg.cur_wdata  = nextis.address;
  assign edreg.period_we  = ed_accept && !nextis.chan_type[1];
  assign edreg.control_we = ed_accept && (nextis.chan_type == ohci_pkg::CONTROL);
  assign edreg.bulk_we    = ed_accept && (nextis.chan_type == ohci_pkg::BULK);

  // end the head access, copy head into current
  assign edreg.bulk_clr    = bulk_head_acc;
  assign edreg.control_clr = control_head_acc;

  always_comb begin
    dma_addr_o  = '0;
    dma_valid_o = 1'b0;
    dma_type_o  = ohci_pkg::ISOCHRONOUS;
    dma_is_ed_o = 1'b0;
    if (bulk_head_acc) begin
      dma_addr_o  = edreg.bulkhead_q;
      dma_valid_o = 1'b1;
      dma_type_o  = ohci_pkg::BULK;
      dma_is_ed_o = 1'b1;
    end else if (control_head_acc) begin
      dma_addr_o  = edreg.controlhead_q;
      dma_valid_o = 1'b1;
      dma_type_o  = ohci_pkg::CONTROL;
      dma_is_ed_o = 1'b1;
    end else if (nextis_accept) begin
      dma_valid_o = 1'b1;
      dma_is_ed_o = nextis.ed;
      // TD or ED of the right list passes through
      dma_addr_o  = nextis.address;
      dma_type_o  = nextis.chan_type;
      if (nextis.ed && redirect) begin
        if (periodic_i) begin
          // periodic zone resumes the period list
          dma_addr_o = edreg.period_q;
          dma_type_o = ohci_pkg::INTERRUPT;
        end else if (threshold_i) begin
          dma_addr_o = edreg.bulk_q;
          dma_type_o = ohci_pkg::BULK;
        end else begin
          dma_addr_o = edreg.control_q;
          dma_type_o = ohci_pkg::CONTROL;
        end
      end
    end
  end

  // not ready while a head is pending
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      ready_q <= 1'b0;
    end else begin
      ready_q <= !any_active;
    end
  end

  assign nextis.ready = ready_q;

endmodule

/* hw/ohci_list_top.sv */
/*
  OHCI list service top with plain ports.
  nextis_valid_i is a one-cycle strobe, legal only while nextis_ready_o is high.
  The DMA request follows a valid strobe in the same cycle.
*/

`timescale 1ns/1ns

module ohci_list_top (
  input  logic                           clk_i,
  input  logic                           reset_i,
  input  logic                           frame_start_i,
  input  logic [ohci_pkg::CBSR_W-1:0]    cbsr_i,
  // host writes to the list heads
  input  logic                           controlhead_we_i,
  input  logic                           bulkhead_we_i,
  input  logic [ohci_pkg::ED_ADDR_W-1:0] head_addr_i,
  // next ED or TD from the fetcher
  input  logic                           nextis_valid_i,
  input  logic                           nextis_ed_i,
  input  ohci_pkg::channel_e             nextis_type_i,
  input  logic [ohci_pkg::ED_ADDR_W-1:0] nextis_address_i,
  output logic                           nextis_ready_o,
  // DMA read request
  output logic [ohci_pkg::ED_ADDR_W-1:0] nextreadaddress_o,
  output logic                           validdmaaccess_o,
  output ohci_pkg::channel_e             current_type_o,
  output logic                           current_ed_o
);

  logic periodic;
  logic threshold;
  logic control_served;
  logic bulk_served;

  ohci_nextis_if nextis_if_i ();
  ohci_edreg_if  edreg_if_i ();

  assign nextis_if_i.valid     = nextis_valid_i;
  assign nextis_if_i.ed        = nextis_ed_i;
  assign nextis_if_i.chan_type = nextis_type_i;
  assign nextis_if_i.address   = nextis_address_i;
  assign nextis_ready_o        = nextis_if_i.ready;

  // ratio counter fed from the issued ED accesses
  assign control_served = validdmaaccess_o && current_ed_o &&
                          (current_type_o == ohci_pkg::CONTROL);
  assign bulk_served    = validdmaaccess_o && current_ed_o &&
                          (current_type_o == ohci_pkg::BULK);

  ohci_ed_regs ohci_ed_regs_i (
    .clk_i            (clk_i),
    .reset_i          (reset_i),
    .controlhead_we_i (controlhead_we_i),
    .bulkhead_we_i    (bulkhead_we_i),
    .head_addr_i      (head_addr_i),
    .edreg            (edreg_if_i.regs)
  );

  ohci_frame_zone ohci_frame_zone_i (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .frame_start_i (frame_start_i),
    .periodic_o    (periodic)
  );

  ohci_ratio_counter ohci_ratio_counter_i (
    .clk_i            (clk_i),
    .reset_i          (reset_i),
    .frame_start_i    (frame_start_i),
    .cbsr_i           (cbsr_i),
    .control_served_i (control_served),
    .bulk_served_i    (bulk_served),
    .threshold_o      (threshold)
  );

  ohci_listservice ohci_listservice_i (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .periodic_i  (periodic),
    .threshold_i (threshold),
    .nextis      (nextis_if_i.service),
    .edreg       (edreg_if_i.service),
    .dma_addr_o  (nextreadaddress_o),
    .dma_valid_o (validdmaaccess_o),
    .dma_type_o  (current_type_o),
    .dma_is_ed_o (current_ed_o)
  );

endmodule

/* sim/ohci_list_model.svh */
/*
  Reference model of the list service, included inside the testbench module.
  Reads the testbench's DUT input signals directly.
  predict_outputs must run before advance_model in every clock cycle.
*/

`ifndef OHCI_LIST_MODEL_SVH
`define OHCI_LIST_MODEL_SVH

// pointer registers, head flags and counters
logic [ohci_pkg::ED_ADDR_W-1:0]   ref_period;
logic [ohci_pkg::ED_ADDR_W-1:0]   ref_control;
logic [ohci_pkg::ED_ADDR_W-1:0]   ref_bulk;
logic [ohci_pkg::ED_ADDR_W-1:0]   ref_controlhead;
logic [ohci_pkg::ED_ADDR_W-1:0]   ref_bulkhead;
logic                             ref_control_act;
logic                             ref_bulk_act;
logic                             ref_ready;
logic [ohci_pkg::FRAME_CNT_W-1:0] ref_frame_cnt;
logic [ohci_pkg::CBSR_W:0]        ref_ratio_cnt;

// expected DMA request of the current cycle
logic [ohci_pkg::ED_ADDR_W-1:0]   exp_addr;
logic                             exp_valid;
ohci_pkg::channel_e               exp_type;
logic                             exp_ed;

task automatic reset_model();
  ref_period      = '0;
  ref_control     = '0;
  ref_bulk        = '0;
  ref_controlhead = '0;
  ref_bulkhead    = '0;
  ref_control_act = 1'b0;
  ref_bulk_act    = 1'b0;
  ref_ready       = 1'b0;
  ref_frame_cnt   = '0;
  ref_ratio_cnt   = '0;
endtask

// same-cycle request from state and current inputs
task automatic predict_outputs();
  logic periodic;
  logic threshold;
  periodic  = (ref_frame_cnt >= ohci_pkg::PERIODIC_START);
  threshold = (ref_ratio_cnt > {1'b0, cbsr_i});
  exp_addr  = '0;
  exp_valid = 1'b0;
  exp_type  = ohci_pkg::ISOCHRONOUS;
  exp_ed    = 1'b0;
  if (ref_bulk_act) begin
    exp_addr  = ref_bulkhead;
    exp_valid = 1'b1;
    exp_type  = ohci_pkg::BULK;
    exp_ed    = 1'b1;
  end else if (ref_control_act) begin
    exp_addr  = ref_controlhead;
    exp_valid = 1'b1;
    exp_type  = ohci_pkg::CONTROL;
    exp_ed    = 1'b1;
  end else if (nextis_valid_i) begin
    exp_valid = 1'b1;
    exp_ed    = nextis_ed_i;
    exp_addr  = nextis_address_i;
    exp_type  = nextis_type_i;
    // wrong zone or ratio used up
    if (nextis_ed_i && ((nextis_type_i[1] == periodic) || threshold)) begin
      if (periodic) begin
        exp_addr = ref_period;
        exp_type = ohci_pkg::INTERRUPT;
      end else if (threshold) begin
        exp_addr = ref_bulk;
        exp_type = ohci_pkg::BULK;
      end else begin
        exp_addr = ref_control;
        exp_type = ohci_pkg::CONTROL;
      end
    end
  end
endtask

// state after the rising edge
task automatic advance_model();
  logic any_act;
  logic bulk_clr;
  logic control_clr;
  logic ed_take;
  logic control_srv;
  logic bulk_srv;
  any_act     = ref_bulk_act || ref_control_act;
  bulk_clr    = ref_bulk_act;
  control_clr = ref_control_act && !ref_bulk_act;
  ed_take     = nextis_valid_i && nextis_ed_i && !any_act;
  control_srv = exp_valid && exp_ed && (exp_type == ohci_pkg::CONTROL);
  bulk_srv    = exp_valid && exp_ed && (exp_type == ohci_pkg::BULK);
  if (frame_start_i || bulk_srv) begin
    ref_ratio_cnt = '0;
  end else if (control_srv && !(&ref_ratio_cnt)) begin
    ref_ratio_cnt = ref_ratio_cnt + 1'b1;
  end
  if (frame_start_i) begin
    ref_frame_cnt = '0;
  end else if (!(&ref_frame_cnt)) begin
    ref_frame_cnt = ref_frame_cnt + 1'b1;
  end
  ref_ready = !any_act;
  if (ed_take && !nextis_type_i[1]) begin
    ref_period = nextis_address_i;
  end
  // head copied on the clear, old head value
  if (control_clr) begin
    ref_control = ref_controlhead;
  end else if (ed_take && (nextis_type_i == ohci_pkg::CONTROL)) begin
    ref_control = nextis_address_i;
  end
  if (bulk_clr) begin
    ref_bulk = ref_bulkhead;
  end else if (ed_take && (nextis_type_i == ohci_pkg::BULK)) begin
    ref_bulk = nextis_address_i;
  end
  if (controlhead_we_i) begin
    ref_controlhead = head_addr_i;
  end
  if (bulkhead_we_i) begin
    ref_bulkhead = head_addr_i;
  end
  // rewrite keeps a flag set
  if (controlhead_we_i) begin
    ref_control_act = 1'b1;
  end else if (control_clr) begin
    ref_control_act = 1'b0;
  end
  if (bulkhead_we_i) begin
    ref_bulk_act = 1'b1;
  end else if (bulk_clr) begin
    ref_bulk_act = 1'b0;
  end
endtask

`endif

/* sim/ohci_list_tb.sv */
/*
  Random testbench of the list service top against an included model.
  Inputs change on the falling edge, checks run on the rising edge.
  Stops at the first mismatch.
*/

`timescale 1ns/1ns

module ohci_list_tb;

  localparam int STIM_CYCLES    = 2000;
  // stimulus plus reset and a margin
  localparam int TIMEOUT_CYCLES = STIM_CYCLES + 200;

  logic                           clk_i;
  logic                           reset_i;
  logic                           frame_start_i;
  logic [ohci_pkg::CBSR_W-1:0]    cbsr_i;
  logic                           controlhead_we_i;
  logic                           bulkhead_we_i;
  logic [ohci_pkg::ED_ADDR_W-1:0] head_addr_i;
  logic                           nextis_valid_i;
  logic                           nextis_ed_i;
  ohci_pkg::channel_e             nextis_type_i;
  logic [ohci_pkg::ED_ADDR_W-1:0] nextis_address_i;
  logic                           nextis_ready_o;
  logic [ohci_pkg::ED_ADDR_W-1:0] nextreadaddress_o;
  logic                           validdmaaccess_o;
  ohci_pkg::channel_e             current_type_o;
  logic                           current_ed_o;

  integer seed;
  int     cycle_cnt = 0;
  int     fail_cnt = 0;

  `include "ohci_list_model.svh"

  ohci_list_top ohci_list_top_i (
    .clk_i             (clk_i),
    .reset_i           (reset_i),
    .frame_start_i     (frame_start_i),
    .cbsr_i            (cbsr_i),
    .controlhead_we_i  (controlhead_we_i),
    .bulkhead_we_i     (bulkhead_we_i),
    .head_addr_i       (head_addr_i),
    .nextis_valid_i    (nextis_valid_i),
    .nextis_ed_i       (nextis_ed_i),
    .nextis_type_i     (nextis_type_i),
    .nextis_address_i  (nextis_address_i),
    .nextis_ready_o    (nextis_ready_o),
    .nextreadaddress_o (nextreadaddress_o),
    .validdmaaccess_o  (validdmaaccess_o),
    .current_type_o    (current_type_o),
    .current_ed_o      (current_ed_o)
  );

  initial clk_i = 1'b0;
  always #2 clk_i = ~clk_i;

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
    fail_cnt++;
    $display("mismatch %s: got 0x%h expected 0x%h", name, got, exp);
    $display("STATUS: FAIL");
    $fatal(1, "stopped at first error");
  endtask

  // strobes low, data zero
  task automatic drive_idle();
    frame_start_i    = 1'b0;
    controlhead_we_i = 1'b0;
    bulkhead_we_i    = 1'b0;
    head_addr_i      = '0;
    nextis_valid_i   = 1'b0;
    nextis_ed_i      = 1'b0;
    nextis_type_i    = ohci_pkg::ISOCHRONOUS;
    nextis_address_i = '0;
  endtask

  always @(posedge clk_i) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt > TIMEOUT_CYCLES) begin
      $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("STATUS: FAIL");
      $fatal(1, "timeout");
    end else if (reset_i) begin
      reset_model();
    end else begin
      predict_outputs();
      assert (validdmaaccess_o === exp_valid)
        else report_mismatch("validdmaaccess_o", 32'(validdmaaccess_o), 32'(exp_valid));
      assert (nextreadaddress_o === exp_addr)
        else report_mismatch("nextreadaddress_o", 32'(nextreadaddress_o), 32'(exp_addr));
      assert (current_type_o === exp_type)
        else report_mismatch("current_type_o", 32'(current_type_o), 32'(exp_type));
      assert (current_ed_o === exp_ed)
        else report_mismatch("current_ed_o", 32'(current_ed_o), 32'(exp_ed));
      assert (nextis_ready_o === ref_ready)
        else report_mismatch("nextis_ready_o", 32'(nextis_ready_o), 32'(ref_ready));
      advance_model();
    end
  end

  initial begin
    int          choice;
    int          hold_cnt;
    logic        busy;
    logic [31:0] rnd;
    seed     = 83;
    hold_cnt = 0;
    reset_i  = 1'b1;
    cbsr_i   = '0;
    drive_idle();
    repeat (3) @(posedge clk_i);
    @(negedge clk_i);
    reset_i = 1'b0;
    // registers still hold reset values here
    assert (nextis_ready_o === 1'b0)
      else report_mismatch("nextis_ready_o", 32'(nextis_ready_o), 32'(1'b0));
    assert (validdmaaccess_o === 1'b0)
      else report_mismatch("validdmaaccess_o", 32'(validdmaaccess_o), 32'(1'b0));
    @(negedge clk_i);
    // one cycle after release
    assert (nextis_ready_o === 1'b1)
      else report_mismatch("nextis_ready_o", 32'(nextis_ready_o), 32'(1'b1));
    for (int n = 0; n < STIM_CYCLES; n++) begin
      drive_idle();
      // no strobe in the two cycles after a head write
      busy = (hold_cnt > 0);
      if (busy) begin
        hold_cnt--;
      end
      choice = $unsigned($random(seed)) % 100;
      rnd    = $random(seed);
      if (choice < 2) begin
        // new frame, new service ratio
        frame_start_i = 1'b1;
        cbsr_i        = rnd[ohci_pkg::CBSR_W-1:0];
      end else if (choice < 7) begin
        // control, bulk or both heads
        head_addr_i      = rnd[ohci_pkg::ED_ADDR_W-1:0];
        controlhead_we_i = rnd[30];
        bulkhead_we_i    = rnd[31] || !rnd[30];
        hold_cnt         = 2;
      end else if (!busy && nextis_ready_o && choice < 85) begin
        nextis_valid_i   = 1'b1;
        nextis_ed_i      = (choice >= 35);
        nextis_type_i    = ohci_pkg::channel_e'(rnd[29:28]);
        nextis_address_i = rnd[ohci_pkg::ED_ADDR_W-1:0];
      end
      @(negedge clk_i);
    end
    drive_idle();
    @(negedge clk_i);
    if (fail_cnt == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

/* flist.f */
+incdir+sim
hw/ohci_pkg.sv
hw/ohci_nextis_if.sv
hw/ohci_edreg_if.sv
hw/ohci_ed_regs.sv
hw/ohci_frame_zone.sv
hw/ohci_ratio_counter.sv
hw/ohci_listservice.sv
hw/ohci_list_top.sv
sim/ohci_list_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := ohci_list_tb
FLIST     := flist.f
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
SRCS      := $(wildcard hw/*.sv sim/*.sv sim/*.svh)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(SIM_BIN)
	@$(SIM_BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "^STATUS: PASS$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
